// ==== xxh_pkg.sv ====
`default_nettype none

package xxh_pkg;

	// message words and hash values
	typedef logic [31:0] word_t;

	// byte counts
	typedef logic [31:0] len_t;

	// one of the four stripe lanes
	typedef logic [1:0] lane_idx_t;

	////////////////////////////////////////////////////////////////////////////
	// XXH32 multipliers
	localparam word_t PRIME32_1 = 32'h9E3779B1;
	localparam word_t PRIME32_2 = 32'h85EBCA77;
	localparam word_t PRIME32_3 = 32'hC2B2AE3D;
	localparam word_t PRIME32_4 = 32'h27D4EB2F;
	localparam word_t PRIME32_5 = 32'h165667B1;

	////////////////////////////////////////////////////////////////////////////
	// phases of one message
	typedef enum logic [2:0]
	{
		ST_IDLE   = 3'd0,
		ST_STRIPE = 3'd1,
		ST_TAIL   = 3'd2,
		ST_BYTES  = 3'd3,
		ST_AVAL   = 3'd4,
		ST_DONE   = 3'd5
	} state_t;

	// rotate left, amount 1 to 31
	function automatic word_t rotl32(input word_t x, input logic [4:0] amt);
		return (x << amt) | (x >> (6'd32 - amt));
	endfunction

endpackage

`default_nettype wire

// ==== xxh_ctrl_if.sv ====
`default_nettype none

interface xxh_ctrl_if;

	// copied from the top level
	logic              start;
	xxh_pkg::len_t     length;

	// phase strobes from the fsm
	logic              init_en;
	logic              stripe_en;
	logic              tail_en;
	logic              load_en;
	logic              byte_en;
	logic              aval_en;
	logic              done_pulse;

	// counter results
	// flags describe the count after the current edge
	xxh_pkg::lane_idx_t lane_sel;
	logic              stripes_left;
	logic              words_left;
	logic              bytes_left;
	xxh_pkg::len_t     msg_len;

	modport fsm (
		input  start, stripes_left, words_left, bytes_left,
		output init_en, stripe_en, tail_en, load_en, byte_en, aval_en, done_pulse
	);

	modport counter (
		input  length, init_en, stripe_en, tail_en, byte_en,
		output lane_sel, stripes_left, words_left, bytes_left, msg_len
	);

	modport datapath (
		input  start, length, init_en, stripe_en, tail_en, load_en, byte_en, aval_en,
		input  done_pulse, lane_sel, stripes_left, words_left, bytes_left, msg_len
	);

endinterface

`default_nettype wire

// ==== xxh_fsm.sv ====
`default_nettype none

module xxh_fsm (
	input  logic     clk,
	input  logic     rstN,
	input  logic     data_valid,
	xxh_ctrl_if.fsm  ctl
);

	xxh_pkg::state_t state;
	xxh_pkg::state_t next_state;
	xxh_pkg::state_t phase;

	// partial word sits in the byte shifter
	logic bytes_loaded;

	// where the message stands once this edge has been taken
	always_comb
	begin
		if (ctl.stripes_left)
			phase = xxh_pkg::ST_STRIPE;
		else if (ctl.words_left)
			phase = xxh_pkg::ST_TAIL;
		else if (ctl.bytes_left)
			phase = xxh_pkg::ST_BYTES;
		else
			phase = xxh_pkg::ST_AVAL;
	end

	////////////////////////////////////////////////////////////////////////////
	// strobes and next state
	always_comb
	begin
		ctl.init_en    = 1'b0;
		ctl.stripe_en  = 1'b0;
		ctl.tail_en    = 1'b0;
		ctl.load_en    = 1'b0;
		ctl.byte_en    = 1'b0;
		ctl.aval_en    = 1'b0;
		ctl.done_pulse = 1'b0;
		next_state     = state;
		case (state)
			xxh_pkg::ST_IDLE:
			begin
				ctl.init_en = ctl.start;
				if (ctl.start)
					next_state = phase;
			end
			xxh_pkg::ST_STRIPE:
			begin
				ctl.stripe_en = data_valid;
				next_state    = phase;
			end
			xxh_pkg::ST_TAIL:
			begin
				ctl.tail_en = data_valid;
				next_state  = phase;
			end
			xxh_pkg::ST_BYTES:
			begin
				// wait for the partial word, then one byte per cycle
				ctl.load_en = data_valid && !bytes_loaded;
				ctl.byte_en = bytes_loaded;
				next_state  = phase;
			end
			xxh_pkg::ST_AVAL:
			begin
				ctl.aval_en = 1'b1;
				next_state  = xxh_pkg::ST_DONE;
			end
			xxh_pkg::ST_DONE:
			begin
				ctl.done_pulse = 1'b1;
				next_state     = xxh_pkg::ST_IDLE;
			end
			default:
			begin
				next_state = xxh_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state        <= xxh_pkg::ST_IDLE;
			bytes_loaded <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (ctl.init_en)
				bytes_loaded <= 1'b0;
			else if (ctl.load_en)
				bytes_loaded <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== xxh_byte_counter.sv ====
`default_nettype none

module xxh_byte_counter (
	input  logic        clk,
	input  logic        rstN,
	xxh_ctrl_if.counter ctl
);

	xxh_pkg::len_t cnt;
	xxh_pkg::len_t cnt_next;
	xxh_pkg::len_t len_q;
	xxh_pkg::len_t len_next;
	xxh_pkg::len_t stripe_end;
	xxh_pkg::len_t word_end;

	// count of consumed bytes after this edge
	always_comb
	begin
		if (ctl.init_en)
		begin
			cnt_next = '0;
			len_next = ctl.length;
		end
		else
		begin
			len_next = len_q;
			if (ctl.stripe_en || ctl.tail_en)
				cnt_next = cnt + 32'd4;
			else if (ctl.byte_en)
				cnt_next = cnt + 32'd1;
			else
				cnt_next = cnt;
		end
	end

	// end of the whole stripes and of the whole words
	assign stripe_end = {len_next[31:4], 4'b0000};
	assign word_end   = {len_next[31:2], 2'b00};

	// lookahead flags so the fsm can change phase at the same edge
	assign ctl.stripes_left = (cnt_next < stripe_end);
	assign ctl.words_left   = (cnt_next < word_end);
	assign ctl.bytes_left   = (cnt_next < len_next);

	// lane of the word arriving now
	assign ctl.lane_sel = cnt[3:2];
	assign ctl.msg_len  = len_q;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			cnt   <= '0;
			len_q <= '0;
		end
		else
		begin
			cnt   <= cnt_next;
			len_q <= len_next;
		end
	end

endmodule

`default_nettype wire

// ==== xxh_lane_bank.sv ====
`default_nettype none

module xxh_lane_bank #(
	parameter xxh_pkg::word_t SEED = '0
) (
	input  logic                clk,
	input  logic                rstN,
	input  xxh_pkg::word_t      data,
	xxh_ctrl_if.datapath        ctl,
	output xxh_pkg::word_t      merged
);

	xxh_pkg::word_t lane [4];
	xxh_pkg::word_t lane_cur;
	xxh_pkg::word_t round_out;

	assign lane_cur = lane[ctl.lane_sel];

	// stripe round on the selected lane
	always_comb
	begin
		round_out = lane_cur + data * xxh_pkg::PRIME32_2;
		round_out = xxh_pkg::rotl32(round_out, 5'd13);
		round_out = round_out * xxh_pkg::PRIME32_1;
	end

	////////////////////////////////////////////////////////////////////////////
	// lane registers
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 4; i++)
				lane[i] <= '0;
		end
		else if (ctl.init_en)
		begin
			lane[0] <= SEED + xxh_pkg::PRIME32_1 + xxh_pkg::PRIME32_2;
			lane[1] <= SEED + xxh_pkg::PRIME32_2;
			lane[2] <= SEED;
			lane[3] <= SEED - xxh_pkg::PRIME32_1;
		end
		else if (ctl.stripe_en)
		begin
			lane[ctl.lane_sel] <= round_out;
		end
	end

	// lane merge, only meaningful after at least one stripe
	assign merged = xxh_pkg::rotl32(lane[0], 5'd1)
		+ xxh_pkg::rotl32(lane[1], 5'd7)
		+ xxh_pkg::rotl32(lane[2], 5'd12)
		+ xxh_pkg::rotl32(lane[3], 5'd18);

endmodule

`default_nettype wire

// ==== xxh_digest_unit.sv ====
`default_nettype none

module xxh_digest_unit #(
	parameter xxh_pkg::word_t SEED = '0
) (
	input  logic                clk,
	input  logic                rstN,
	input  xxh_pkg::word_t      data,
	input  xxh_pkg::word_t      merged,
	xxh_ctrl_if.datapath        ctl,
	output xxh_pkg::word_t      digest,
	output logic                digest_valid
);

	xxh_pkg::word_t hash_q;
	xxh_pkg::word_t h_start;
	xxh_pkg::word_t h_cur;
	xxh_pkg::word_t shifter;

	// hash not yet touched since start
	logic h_fresh;

	// one leftover whole word
	function automatic xxh_pkg::word_t tail_round(input xxh_pkg::word_t h,
		input xxh_pkg::word_t w);
		xxh_pkg::word_t t;
		t = h + w * xxh_pkg::PRIME32_3;
		t = xxh_pkg::rotl32(t, 5'd17);
		return t * xxh_pkg::PRIME32_4;
	endfunction

	// one leftover byte
	function automatic xxh_pkg::word_t byte_round(input xxh_pkg::word_t h,
		input logic [7:0] b);
		xxh_pkg::word_t t;
		t = h + {24'h000000, b} * xxh_pkg::PRIME32_5;
		t = xxh_pkg::rotl32(t, 5'd11);
		return t * xxh_pkg::PRIME32_1;
	endfunction

	function automatic xxh_pkg::word_t avalanche(input xxh_pkg::word_t h);
		xxh_pkg::word_t t;
		t = h ^ (h >> 15);
		t = t * xxh_pkg::PRIME32_2;
		t = t ^ (t >> 13);
		t = t * xxh_pkg::PRIME32_3;
		return t ^ (t >> 16);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// start value, short messages skip the lanes
	assign h_start = ((ctl.msg_len >= 32'd16) ? merged : SEED + xxh_pkg::PRIME32_5)
		+ ctl.msg_len;
	assign h_cur = h_fresh ? h_start : hash_q;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			h_fresh      <= 1'b0;
			hash_q       <= '0;
			digest       <= '0;
			digest_valid <= 1'b0;
		end
		else
		begin
			digest_valid <= ctl.done_pulse;
			if (ctl.done_pulse)
				digest <= hash_q;
			if (ctl.init_en)
				h_fresh <= 1'b1;
			else if (ctl.tail_en || ctl.byte_en || ctl.aval_en)
				h_fresh <= 1'b0;
			if (ctl.tail_en)
				hash_q <= tail_round(h_cur, data);
			else if (ctl.byte_en)
				hash_q <= byte_round(h_cur, shifter[7:0]);
			else if (ctl.aval_en)
				hash_q <= avalanche(h_cur);
		end
	end

	// partial word, lowest byte first
	always_ff @(posedge clk)
	begin
		if (ctl.load_en)
			shifter <= data;
		else if (ctl.byte_en)
			shifter <= {8'h00, shifter[31:8]};
	end

endmodule

`default_nettype wire

// ==== xxh32_core.sv ====
`default_nettype none

module xxh32_core #(
	parameter xxh_pkg::word_t SEED = '0
) (
	input  logic           clk,
	input  logic           rstN,
	input  logic           start,
	input  xxh_pkg::len_t  length,
	input  xxh_pkg::word_t data,
	input  logic           data_valid,
	output xxh_pkg::word_t digest,
	output logic           digest_valid
);

	xxh_pkg::word_t merged;

	xxh_ctrl_if ctl ();

	assign ctl.start  = start;
	assign ctl.length = length;

	////////////////////////////////////////////////////////////////////////////
	// control
	xxh_fsm fsm_inst (
		.clk        (clk),
		.rstN       (rstN),
		.data_valid (data_valid),
		.ctl        (ctl.fsm)
	);

	xxh_byte_counter counter_inst (
		.clk  (clk),
		.rstN (rstN),
		.ctl  (ctl.counter)
	);

	////////////////////////////////////////////////////////////////////////////
	// datapath
	xxh_lane_bank #(
		.SEED (SEED)
	) lane_bank_inst (
		.clk    (clk),
		.rstN   (rstN),
		.data   (data),
		.ctl    (ctl.datapath),
		.merged (merged)
	);

	xxh_digest_unit #(
		.SEED (SEED)
	) digest_unit_inst (
		.clk          (clk),
		.rstN         (rstN),
		.data         (data),
		.merged       (merged),
		.ctl          (ctl.datapath),
		.digest       (digest),
		.digest_valid (digest_valid)
	);

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rstN
);

	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset released on a rising edge
	initial
	begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb_xxh32.sv ====
`default_nettype none

module tb_xxh32;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD_NS = 10;
	// a word takes at most four cycles with gaps
	localparam int TOTAL_WORDS   = 302;
	localparam int TOTAL_MSGS    = 53;
	localparam int BUDGET_CYCLES = TOTAL_WORDS * 4 + TOTAL_MSGS * 12 + 100;

	// XXH32 reference constants
	localparam logic [31:0] P1         = 32'h9E3779B1;
	localparam logic [31:0] P2         = 32'h85EBCA77;
	localparam logic [31:0] P3         = 32'hC2B2AE3D;
	localparam logic [31:0] P4         = 32'h27D4EB2F;
	localparam logic [31:0] P5         = 32'h165667B1;
	localparam logic [31:0] MODEL_SEED = 32'h00000000;

	logic        clk;
	logic        rstN;
	logic        start;
	logic [31:0] length;
	logic [31:0] data;
	logic        data_valid;
	logic [31:0] digest;
	logic        digest_valid;

	logic [31:0] lfsr_state = 32'haabf;
	logic [7:0]  msg_bytes[$];
	int          edge_cnt    = 0;
	int          valid_count = 0;
	int          msgs_sent   = 0;
	logic        valid_prev  = 1'b0;

	tb_clock_gen #(
		.PERIOD_NS    (CLK_PERIOD_NS),
		.RESET_CYCLES (10)
	) clock_gen_inst (
		.clk  (clk),
		.rstN (rstN)
	);

	xxh32_core #(
		.SEED (MODEL_SEED)
	) xxh32_core_inst (
		.clk          (clk),
		.rstN         (rstN),
		.start        (start),
		.length       (length),
		.data         (data),
		.data_valid   (data_valid),
		.digest       (digest),
		.digest_valid (digest_valid)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Galois LFSR random source
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic void fill_message(input int len);
		logic [31:0] r;
		msg_bytes.delete();
		for (int i = 0; i < len; i++)
		begin
			r = rand_bits(8);
			msg_bytes.push_back(r[7:0]);
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// software model of XXH32
	function automatic logic [31:0] rotl_word(input logic [31:0] x, input int r);
		return (x << r) | (x >> (32 - r));
	endfunction

	// little endian with the first byte lowest
	function automatic logic [31:0] word_at(input int p);
		return {msg_bytes[p + 3], msg_bytes[p + 2], msg_bytes[p + 1], msg_bytes[p]};
	endfunction

	function automatic logic [31:0] model_digest(input int len);
		logic [31:0] v[4];
		logic [31:0] h;
		int p;
		p = 0;
		h = MODEL_SEED + P5;
		if (len >= 16)
		begin
			v[0] = MODEL_SEED + P1 + P2;
			v[1] = MODEL_SEED + P2;
			v[2] = MODEL_SEED;
			v[3] = MODEL_SEED - P1;
			while (p + 16 <= len)
			begin
				for (int i = 0; i < 4; i++)
				begin
					v[i] = rotl_word(v[i] + word_at(p) * P2, 13) * P1;
					p += 4;
				end
			end
			h = rotl_word(v[0], 1) + rotl_word(v[1], 7)
				+ rotl_word(v[2], 12) + rotl_word(v[3], 18);
		end
		h = h + len;
		while (p + 4 <= len)
		begin
			h = rotl_word(h + word_at(p) * P3, 17) * P4;
			p += 4;
		end
		while (p < len)
		begin
			h = rotl_word(h + {24'h000000, msg_bytes[p]} * P5, 11) * P1;
			p++;
		end
		h = h ^ (h >> 15);
		h = h * P2;
		h = h ^ (h >> 13);
		h = h * P3;
		return h ^ (h >> 16);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// sends one message from a rising edge and returns at the digest_valid edge
	task automatic send_message(input string name, input int len, input bit with_gaps,
		output logic [31:0] got);
		logic [31:0] expected;
		logic [31:0] word;
		logic [31:0] r;
		int nwords;
		int n;
		int last_edge;
		int waited;
		int gap;
		expected  = model_digest(len);
		nwords    = (len + 3) / 4;
		n         = len % 4;
		start     <= 1'b1;
		length    <= len;
		last_edge = edge_cnt + 1;
		@(posedge clk);
		start <= 1'b0;
		for (int w = 0; w < nwords; w++)
		begin
			gap = 0;
			if (with_gaps)
			begin
				r   = rand_bits(2);
				gap = int'(r);
			end
			if (gap > 0)
			begin
				data_valid <= 1'b0;
				repeat (gap) @(posedge clk);
			end
			// bytes past the end are random padding
			for (int b = 0; b < 4; b++)
			begin
				r = rand_bits(8);
				word[8 * b +: 8] = (4 * w + b < len) ? msg_bytes[4 * w + b] : r[7:0];
			end
			data       <= word;
			data_valid <= 1'b1;
			last_edge  = edge_cnt + 1;
			@(posedge clk);
		end
		data_valid <= 1'b0;
		waited = 0;
		do
		begin
			@(posedge clk);
			waited++;
			if (waited > n + 10)
				fail_run($sformatf("no digest_valid for %s message of length %0d", name, len));
		end
		while (!digest_valid);
		got = digest;
		msgs_sent++;
		assert (edge_cnt == last_edge + n + 3)
		else
			fail_run($sformatf("ERROR %s (length %0d) timing: expected edge %0d, actual %0d",
				name, len, last_edge + n + 3, edge_cnt));
		assert (got === expected)
		else
			fail_run($sformatf("ERROR %s (length %0d): expected %h, actual %h",
				name, len, expected, got));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	task automatic check_idle_words();
		logic [31:0] r;
		for (int i = 0; i < 8; i++)
		begin
			r = rand_bits(32);
			data       <= r;
			data_valid <= 1'b1;
			@(posedge clk);
			assert (digest_valid === 1'b0)
			else
				fail_run("digest_valid rose while no message was active");
		end
		data_valid <= 1'b0;
		repeat (4) @(posedge clk);
		assert (valid_count == 0)
		else
			fail_run($sformatf("ERROR idle: expected 0 digests, actual %0d", valid_count));
	endtask

	task automatic run_short_messages();
		logic [31:0] got;
		fill_message(0);
		send_message("empty", 0, 1'b0, got);
		assert (got === 32'h02cc5d05)
		else
			fail_run($sformatf("ERROR empty: expected 02cc5d05, actual %h", got));
		for (int len = 1; len < 16; len++)
		begin
			fill_message(len);
			send_message("short", len, 1'b0, got);
		end
	endtask

	task automatic run_stripe_messages();
		logic [31:0] got;
		for (int len = 16; len <= 64; len = len * 2)
		begin
			fill_message(len);
			send_message("stripes", len, 1'b0, got);
		end
	endtask

	task automatic sweep_tail_lengths();
		logic [31:0] got;
		for (int len = 17; len <= 40; len++)
		begin
			fill_message(len);
			send_message("sweep", len, 1'b0, got);
		end
	endtask

	// same bytes twice so both digests meet the same model value
	task automatic run_gapped_message();
		logic [31:0] got;
		fill_message(37);
		send_message("no gaps", 37, 1'b0, got);
		send_message("gaps", 37, 1'b1, got);
	endtask

	// each start lands right after the previous digest_valid
	task automatic run_back_to_back();
		int lens[8] = '{20, 21, 22, 23, 5, 6, 7, 3};
		logic [31:0] got;
		foreach (lens[i])
		begin
			fill_message(lens[i]);
			send_message("back to back", lens[i], 1'b0, got);
		end
	endtask

	// edge count and digest_valid pulse width
	always @(posedge clk)
	begin
		edge_cnt   <= edge_cnt + 1;
		valid_prev <= digest_valid;
		if (digest_valid)
			valid_count <= valid_count + 1;
		assert (!(digest_valid && valid_prev))
		else
			fail_run("digest_valid stayed high for more than one cycle");
	end

	initial
	begin
		#(BUDGET_CYCLES * CLK_PERIOD_NS);
		fail_run($sformatf("watchdog expired after %0d cycles", BUDGET_CYCLES));
	end

	initial
	begin
		start      = 1'b0;
		length     = '0;
		data       = '0;
		data_valid = 1'b0;
		@(posedge rstN);
		@(posedge clk);
		check_idle_words();
		run_short_messages();
		run_stripe_messages();
		sweep_tail_lengths();
		run_gapped_message();
		run_back_to_back();
		repeat (2) @(posedge clk);
		assert (valid_count == msgs_sent)
		else
			fail_run($sformatf("ERROR digest count: expected %0d, actual %0d",
				msgs_sent, valid_count));
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
xxh_pkg.sv
xxh_ctrl_if.sv
xxh_fsm.sv
xxh_byte_counter.sv
xxh_lane_bank.sv
xxh_digest_unit.sv
xxh32_core.sv
tb_clock_gen.sv
tb_xxh32.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the XXH32 testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_xxh32 -f src.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "all tests passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
